//--- hw/periph_defs.svh
// Bus widths, slave indices and register word offsets
// for the APB peripheral subsystem
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Subsystem bus widths
`define APB_ADDR_W 16
`define APB_DATA_W 32

// Per-slave window is 4 KB
`define SLV_ADDR_W 12
`define SLV_IDX_W  (`APB_ADDR_W - `SLV_ADDR_W)

// Slave index in address bits 15..12
`define SLV_GPIO  4'd0
`define SLV_TIMER 4'd1

// Word offset field within a slave window
`define REG_OFS_LSB 2
`define REG_OFS_W   2

// GPIO register word offsets
`define GPIO_OFS_OUT 2'd0
`define GPIO_OFS_IN  2'd1

// Timer register word offsets
`define TMR_OFS_CTRL  2'd0
`define TMR_OFS_COUNT 2'd1
`define TMR_OFS_CMP   2'd2
`define TMR_OFS_STAT  2'd3

`endif

//--- hw/apb_pkg.sv
// APB address and data types
// Request and response structs for the subsystem port and the slaves
`include "periph_defs.svh"

package apb_pkg;

   // Full subsystem address
   typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

   // Address inside one slave window
   typedef logic [`SLV_ADDR_W-1:0] apb_slv_addr_t;

   // Read and write data word
   typedef logic [`APB_DATA_W-1:0] apb_data_t;

   // Master side request, PSEL/PENABLE/PWRITE/PADDR/PWDATA
   typedef struct packed {
      logic      sel;
      logic      enable;
      logic      write;
      apb_addr_t addr;
      apb_data_t wdata;
   } apb_req_t;

   // Request as seen by one slave
   typedef struct packed {
      logic          sel;
      logic          enable;
      logic          write;
      apb_slv_addr_t addr;
      apb_data_t     wdata;
   } apb_slv_req_t;

   // PRDATA/PREADY/PSLVERR back to the master
   typedef struct packed {
      apb_data_t rdata;
      logic      ready;
      logic      slverr;
   } apb_rsp_t;

endpackage

//--- hw/periph_pkg.sv
// Data types of the GPIO and timer peripherals
// Register word offset type
`include "periph_defs.svh"

package periph_pkg;

   // One bit per pad
   typedef logic [`APB_DATA_W-1:0] gpio_word_t;

   // Timer counter and compare value
   typedef logic [`APB_DATA_W-1:0] timer_count_t;

   // Word offset, address bits 3..2
   typedef logic [`REG_OFS_W-1:0] reg_ofs_t;

endpackage

//--- hw/apb_decoder.sv
// APB address decoder
// Slave selects, read data mux and unmapped access error
`timescale 1ns/1ps
`include "periph_defs.svh"

module apb_decoder
   import apb_pkg::*;
(
   input  apb_req_t     apb_req,
   output apb_rsp_t     apb_rsp,
   output apb_slv_req_t gpio_req,
   input  apb_data_t    gpio_rdata,
   output apb_slv_req_t timer_req,
   input  apb_data_t    timer_rdata
);

   // Slave index taken from the top address bits
   logic [`SLV_IDX_W-1:0] slv_idx;
   logic                  hit_gpio;
   logic                  hit_timer;
   logic                  hit_none;

   // Narrow the request for one slave, select only when it is hit
   function automatic apb_slv_req_t slv_req(input apb_req_t req, input logic hit);
      apb_slv_req_t r;
      r.sel    = req.sel & hit;
      r.enable = req.enable;
      r.write  = req.write;
      r.addr   = req.addr[`SLV_ADDR_W-1:0];
      r.wdata  = req.wdata;
      return r;
   endfunction

   assign slv_idx   = apb_req.addr[`APB_ADDR_W-1:`SLV_ADDR_W];
   assign hit_gpio  = (slv_idx == `SLV_GPIO);
   assign hit_timer = (slv_idx == `SLV_TIMER);
   // Nothing lives at the other indices
   assign hit_none  = ~(hit_gpio | hit_timer);

   assign gpio_req  = slv_req(apb_req, hit_gpio);
   assign timer_req = slv_req(apb_req, hit_timer);

   // Read data mux
   always_comb begin
      apb_rsp.rdata = '0;
      if (hit_gpio) begin
         apb_rsp.rdata = gpio_rdata;
      end else if (hit_timer) begin
         apb_rsp.rdata = timer_rdata;
      end
   end

   // Zero wait states on every slave
   assign apb_rsp.ready  = 1'b1;

   // Error only in the access phase of an unmapped transfer
   assign apb_rsp.slverr = apb_req.sel & apb_req.enable & hit_none;

endmodule

//--- hw/gpio_apb.sv
// GPIO block with APB register access
// Output register to the pads, two-flop input synchronizer
`timescale 1ns/1ps
`include "periph_defs.svh"

module gpio_apb
   import apb_pkg::*;
   import periph_pkg::*;
(
   input  logic         clk_apb,
   input  logic         rst_apb_n,
   input  apb_slv_req_t req,
   output apb_data_t    rdata,
   input  gpio_word_t   pad_in,
   output gpio_word_t   pad_out
);

   reg_ofs_t   ofs;
   logic       rd_en;
   logic       wr_en;
   apb_data_t  rd_mux;

   // Output register
   gpio_word_t out_q;

   // Synchronizer stages
   gpio_word_t in_meta;
   gpio_word_t in_q;

   assign ofs = req.addr[`REG_OFS_LSB +: `REG_OFS_W];

   // Read lasts the whole transfer
   assign rd_en = req.sel & ~req.write;
   // Write only in the setup cycle
   assign wr_en = req.sel & ~req.enable & req.write;

   // Output register write
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (!rst_apb_n) begin
         out_q <= '0;
      end else if (wr_en && ofs == `GPIO_OFS_OUT) begin
         out_q <= req.wdata;
      end
   end

   // Pads are asynchronous to clk_apb
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (!rst_apb_n) begin
         in_meta <= '0;
         in_q    <= '0;
      end else begin
         in_meta <= pad_in;
         in_q    <= in_meta;
      end
   end

   // Register read mux
   always_comb begin
      case (ofs)
         `GPIO_OFS_OUT: rd_mux = out_q;
         `GPIO_OFS_IN:  rd_mux = in_q;
         // Offsets 2 and 3 are unused
         default:       rd_mux = '0;
      endcase
   end

   // Zero outside a read
   assign rdata = rd_en ? rd_mux : '0;

   assign pad_out = out_q;

endmodule

//--- hw/timer_apb.sv
// Timer block with APB register access
// Free-running counter, compare, sticky match flag and irq
`timescale 1ns/1ps
`include "periph_defs.svh"

module timer_apb
   import apb_pkg::*;
   import periph_pkg::*;
(
   input  logic         clk_apb,
   input  logic         rst_apb_n,
   input  apb_slv_req_t req,
   output apb_data_t    rdata,
   output logic         irq
);

   reg_ofs_t     ofs;
   logic         rd_en;
   logic         wr_en;
   logic         match;
   logic         stat_clr;
   apb_data_t    rd_mux;

   // CTRL bit 0
   logic         en_q;
   timer_count_t count_q;
   timer_count_t cmp_q;
   // STAT bit 0, sticky
   logic         stat_q;

   assign ofs = req.addr[`REG_OFS_LSB +: `REG_OFS_W];

   assign rd_en = req.sel & ~req.write;
   // Setup cycle write strobe
   assign wr_en = req.sel & ~req.enable & req.write;

   // Compare only counts while running
   assign match = en_q & (count_q == cmp_q);

   // Write 1 to clear
   assign stat_clr = wr_en & (ofs == `TMR_OFS_STAT) & req.wdata[0];

   // Enable and compare registers
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (!rst_apb_n) begin
         en_q  <= 1'b0;
         cmp_q <= '0;
      end else if (wr_en) begin
         if (ofs == `TMR_OFS_CTRL) begin
            en_q <= req.wdata[0];
         end
         if (ofs == `TMR_OFS_CMP) begin
            cmp_q <= req.wdata;
         end
      end
   end

   // Bus write to the counter beats the increment
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (!rst_apb_n) begin
         count_q <= '0;
      end else if (wr_en && ofs == `TMR_OFS_COUNT) begin
         count_q <= req.wdata;
      end else if (en_q) begin
         // Wraps at 2^32
         count_q <= count_q + 1;
      end
   end

   // Clear beats a same-cycle match
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (!rst_apb_n) begin
         stat_q <= 1'b0;
      end else if (stat_clr) begin
         stat_q <= 1'b0;
      end else if (match) begin
         stat_q <= 1'b1;
      end
   end

   // Register read mux
   always_comb begin
      case (ofs)
         `TMR_OFS_CTRL:  rd_mux = {{(`APB_DATA_W-1){1'b0}}, en_q};
         `TMR_OFS_COUNT: rd_mux = count_q;
         `TMR_OFS_CMP:   rd_mux = cmp_q;
         default:        rd_mux = {{(`APB_DATA_W-1){1'b0}}, stat_q};
      endcase
   end

   assign rdata = rd_en ? rd_mux : '0;

   // Level interrupt straight from the flag
   assign irq = stat_q;

endmodule

//--- hw/periph_subsys.sv
// APB peripheral subsystem top level
// Decoder with GPIO and timer slaves
`timescale 1ns/1ps

module periph_subsys
   import apb_pkg::*;
   import periph_pkg::*;
(
   input  logic       clk_apb,
   input  logic       rst_apb_n,
   input  apb_req_t   apb_req,
   output apb_rsp_t   apb_rsp,
   input  gpio_word_t pad_in,
   output gpio_word_t pad_out,
   output logic       timer_irq
);

   // Per-slave requests
   apb_slv_req_t gpio_req;
   apb_slv_req_t timer_req;

   // Per-slave read data
   apb_data_t    gpio_rdata;
   apb_data_t    timer_rdata;

   apb_decoder decoder_i (
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .gpio_req    (gpio_req),
      .gpio_rdata  (gpio_rdata),
      .timer_req   (timer_req),
      .timer_rdata (timer_rdata)
   );

   // Slave 0
   gpio_apb gpio_i (
      .clk_apb   (clk_apb),
      .rst_apb_n (rst_apb_n),
      .req       (gpio_req),
      .rdata     (gpio_rdata),
      .pad_in    (pad_in),
      .pad_out   (pad_out)
   );

   // Slave 1
   timer_apb timer_i (
      .clk_apb   (clk_apb),
      .rst_apb_n (rst_apb_n),
      .req       (timer_req),
      .rdata     (timer_rdata),
      .irq       (timer_irq)
   );

endmodule

//--- verif/periph_subsys_assert.sv
// Concurrent checks on the APB response and the timer interrupt
// Bound into the subsystem top level
`timescale 1ns/1ps

module periph_subsys_assert
   import apb_pkg::*;
(
   input logic     clk_apb,
   input logic     rst_apb_n,
   input apb_req_t apb_req,
   input apb_rsp_t apb_rsp,
   input logic     timer_irq
);

   // Failures per property
   int ready_fails  = 0;
   int slverr_fails = 0;
   int irq_fails    = 0;
   int fail_count;

   assign fail_count = ready_fails + slverr_fails + irq_fails;

   // Zero wait states
   ready_high: assert property (@(posedge clk_apb) disable iff (!rst_apb_n)
      apb_rsp.ready)
      else begin
         $error("PREADY dropped low");
         ready_fails++;
      end

   // Error response only in an access cycle
   slverr_in_access: assert property (@(posedge clk_apb) disable iff (!rst_apb_n)
      apb_rsp.slverr |-> (apb_req.sel && apb_req.enable))
      else begin
         $error("PSLVERR high outside an access cycle");
         slverr_fails++;
      end

   // Flag starts cleared
   irq_low_after_reset: assert property (@(posedge clk_apb)
      $rose(rst_apb_n) |-> !timer_irq)
      else begin
         $error("timer_irq high right after reset release");
         irq_fails++;
      end

endmodule

bind periph_subsys periph_subsys_assert periph_subsys_assert_i (
   .clk_apb   (clk_apb),
   .rst_apb_n (rst_apb_n),
   .apb_req   (apb_req),
   .apb_rsp   (apb_rsp),
   .timer_irq (timer_irq)
);

//--- verif/periph_subsys_tb.sv
// Testbench for the APB peripheral subsystem
// Stimulus table of APB transfers, compare tasks, watchdog and verdict
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_subsys_tb;
   import apb_pkg::*;
   import periph_pkg::*;

   localparam int HALF_PERIOD  = 50;
   localparam int QUARTER      = 25;
   localparam int RESET_CYCLES = 8;
   // Cycle budget per table entry
   localparam int STEP_BUDGET  = 10;
   // Counter runs 0..20, flag sets one edge later
   localparam int IRQ_WAIT_MAX = 40;

   // What happens to timer_irq around an entry
   typedef logic [1:0] irq_op_t;
   localparam irq_op_t IRQ_NONE = 2'd0;
   localparam irq_op_t IRQ_LOW  = 2'd1;
   localparam irq_op_t IRQ_WAIT = 2'd2;

   // One table row
   typedef struct packed {
      logic       write;
      apb_addr_t  addr;
      apb_data_t  wdata;
      gpio_word_t pad;
      apb_data_t  exp_rdata;
      logic       exp_slverr;
      irq_op_t    irq_op;
   } step_t;

   logic       clk_apb;
   logic       rst_apb_n;
   apb_req_t   apb_req;
   apb_rsp_t   apb_rsp;
   gpio_word_t pad_in;
   gpio_word_t pad_out;
   logic       timer_irq;

   step_t      steps[$];
   int         seed = 32'h65949a08;
   int         watchdog_cycles;
   logic       table_ready = 1'b0;
   // Expected pad_out from the GPIO OUT writes so far
   gpio_word_t model_out;

   periph_subsys periph_subsys_i (
      .clk_apb   (clk_apb),
      .rst_apb_n (rst_apb_n),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .pad_in    (pad_in),
      .pad_out   (pad_out),
      .timer_irq (timer_irq)
   );

   initial clk_apb = 1'b0;
   always #(HALF_PERIOD) clk_apb = ~clk_apb;

   task automatic stop_with_fail();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic check_word(input string name, input gpio_word_t got, input gpio_word_t exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_fail();
      end
   endtask

   function automatic gpio_word_t next_pad();
      return $random(seed);
   endfunction

   task automatic add_step(input logic w, input apb_addr_t a, input apb_data_t wd,
                           input gpio_word_t pad, input apb_data_t rd, input logic err,
                           input irq_op_t op);
      step_t s;
      s.write      = w;
      s.addr       = a;
      s.wdata      = wd;
      s.pad        = pad;
      s.exp_rdata  = rd;
      s.exp_slverr = err;
      s.irq_op     = op;
      steps.push_back(s);
   endtask

   // Expected values follow the register rules, writes read back zero
   task automatic build_table();
      apb_data_t  out_a;
      apb_data_t  out_b;
      apb_data_t  cmp_v;
      gpio_word_t pad_a;
      gpio_word_t pad_b;
      out_a = $random(seed);
      out_b = $random(seed);
      cmp_v = $random(seed);
      pad_a = next_pad();
      pad_b = next_pad();
      // GPIO OUT write and readback
      add_step(1'b1, 16'h0000, 32'hA5A5_0F0F, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b0, 16'h0000, '0, next_pad(), 32'hA5A5_0F0F, 1'b0, IRQ_NONE);
      add_step(1'b1, 16'h0000, out_a, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b0, 16'h0000, '0, next_pad(), out_a, 1'b0, IRQ_NONE);
      add_step(1'b1, 16'h0000, out_b, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b0, 16'h0000, '0, next_pad(), out_b, 1'b0, IRQ_NONE);
      // GPIO IN through the synchronizer, unused offsets
      add_step(1'b0, 16'h0004, '0, pad_a, pad_a, 1'b0, IRQ_NONE);
      add_step(1'b0, 16'h0004, '0, pad_b, pad_b, 1'b0, IRQ_NONE);
      add_step(1'b0, 16'h0008, '0, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b0, 16'h000C, '0, next_pad(), '0, 1'b0, IRQ_NONE);
      // Unmapped slaves
      add_step(1'b1, 16'h2000, 32'hDEAD_BEEF, next_pad(), '0, 1'b1, IRQ_NONE);
      add_step(1'b0, 16'h2000, '0, next_pad(), '0, 1'b1, IRQ_NONE);
      add_step(1'b0, 16'hF004, '0, next_pad(), '0, 1'b1, IRQ_NONE);
      add_step(1'b1, 16'h3000, 32'h1234_5678, next_pad(), '0, 1'b1, IRQ_NONE);
      add_step(1'b0, 16'h0000, '0, next_pad(), out_b, 1'b0, IRQ_NONE);
      // Timer COUNT 0, CMP 20, enable, then wait for the match
      add_step(1'b1, 16'h1004, 32'd0, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b1, 16'h1008, 32'd20, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b1, 16'h1000, 32'd1, next_pad(), '0, 1'b0, IRQ_LOW);
      add_step(1'b0, 16'h100C, '0, next_pad(), 32'd1, 1'b0, IRQ_WAIT);
      add_step(1'b0, 16'h1000, '0, next_pad(), 32'd1, 1'b0, IRQ_NONE);
      // Disable, clear the flag, CMP readback
      add_step(1'b1, 16'h1000, 32'd0, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b1, 16'h100C, 32'd1, next_pad(), '0, 1'b0, IRQ_LOW);
      add_step(1'b0, 16'h100C, '0, next_pad(), 32'd0, 1'b0, IRQ_LOW);
      add_step(1'b1, 16'h1008, cmp_v, next_pad(), '0, 1'b0, IRQ_NONE);
      add_step(1'b0, 16'h1008, '0, next_pad(), cmp_v, 1'b0, IRQ_NONE);
   endtask

   task automatic wait_irq_high();
      int cycles;
      cycles = 0;
      while (timer_irq !== 1'b1 && cycles < IRQ_WAIT_MAX) begin
         @(negedge clk_apb);
         cycles++;
      end
      if (timer_irq !== 1'b1) begin
         $display("timer_irq did not rise within %0d cycles of waiting", IRQ_WAIT_MAX);
         stop_with_fail();
      end
   endtask

   // pad_in three cycles ahead, then setup and access cycles
   task automatic run_step(input step_t s, input int idx);
      string tag;
      tag = $sformatf("step %0d", idx);
      if (s.irq_op == IRQ_WAIT) begin
         wait_irq_high();
      end
      @(negedge clk_apb);
      pad_in = s.pad;
      repeat (2) @(negedge clk_apb);
      @(negedge clk_apb);
      apb_req.sel    = 1'b1;
      apb_req.enable = 1'b0;
      apb_req.write  = s.write;
      apb_req.addr   = s.addr;
      apb_req.wdata  = s.wdata;
      #(QUARTER);
      check_data({"apb_rsp.rdata setup ", tag}, apb_rsp.rdata, s.exp_rdata);
      check_bit({"apb_rsp.slverr setup ", tag}, apb_rsp.slverr, 1'b0);
      @(negedge clk_apb);
      apb_req.enable = 1'b1;
      #(QUARTER);
      check_data({"apb_rsp.rdata access ", tag}, apb_rsp.rdata, s.exp_rdata);
      check_bit({"apb_rsp.slverr access ", tag}, apb_rsp.slverr, s.exp_slverr);
      @(negedge clk_apb);
      apb_req = '0;
      // Only a mapped GPIO OUT write moves the pads
      if (s.write && s.addr[`APB_ADDR_W-1:`SLV_ADDR_W] == `SLV_GPIO &&
          s.addr[`REG_OFS_LSB +: `REG_OFS_W] == `GPIO_OFS_OUT) begin
         model_out = s.wdata;
      end
      check_word({"pad_out ", tag}, pad_out, model_out);
      if (s.irq_op == IRQ_LOW) begin
         check_bit({"timer_irq ", tag}, timer_irq, 1'b0);
      end
   endtask

   initial begin
      apb_req   = '0;
      pad_in    = '0;
      rst_apb_n = 1'b0;
      model_out = '0;
      build_table();
      watchdog_cycles = steps.size() * STEP_BUDGET + IRQ_WAIT_MAX + RESET_CYCLES;
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk_apb);
      rst_apb_n = 1'b1;
      @(negedge clk_apb);
      check_bit("timer_irq after reset", timer_irq, 1'b0);
      check_word("pad_out after reset", pad_out, '0);
      for (int i = 0; i < steps.size(); i++) begin
         run_step(steps[i], i);
      end
      @(negedge clk_apb);
      if (periph_subsys_i.periph_subsys_assert_i.fail_count == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Bound assertions failed during the run");
         stop_with_fail();
      end
   end

   // Bound assertion failures end the run
   always @(negedge clk_apb) begin
      if (periph_subsys_i.periph_subsys_assert_i.fail_count != 0) begin
         $display("A bound assertion on the APB response or timer_irq failed");
         stop_with_fail();
      end
   end

   initial begin
      wait (table_ready);
      repeat (watchdog_cycles) @(posedge clk_apb);
      $display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
      stop_with_fail();
   end

endmodule

//--- src.f
+incdir+hw
hw/apb_pkg.sv
hw/periph_pkg.sv
hw/apb_decoder.sv
hw/gpio_apb.sv
hw/timer_apb.sv
hw/periph_subsys.sv
verif/periph_subsys_assert.sv
verif/periph_subsys_tb.sv

//--- Makefile
# Verilator build and run of the APB peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= periph_subsys_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Finished with no errors

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
